//--- Bender.yml
package:
  name: mem_subsystem

dependencies: {}

sources:
  # Packages first, then the blocks, then the top level
  - rtl/cache_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/l1_cache_2way.sv
  - rtl/cache_ctrl.sv
  - rtl/backing_ram.sv
  - rtl/mem_subsystem.sv

  - target: test
    files:
      - dv/mem_subsystem_tb.sv

//--- dv/mem_subsystem_tb.sv
//----------------------------------------------------------------------------
// Memory subsystem testbench
// Random loads and stores checked against a reference memory and a
// cache-state model that predicts the hit flag of every request
//----------------------------------------------------------------------------
module mem_subsystem_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 2000;
    localparam int N_DIRECTED   = 5;
    localparam int N_SETS       = 2**cache_pkg::SET_WIDTH;
    localparam int TAG_SHIFT    = cache_pkg::SET_WIDTH + cache_pkg::OFFSET_WIDTH;
    // Worst case is well under 8 cycles per request
    localparam int TIMEOUT      = ((N_RANDOM + N_DIRECTED) * 8 + RESET_CYCLES) * CLK_PERIOD;

    // Conflict addresses in set 3, tags 1, 2 and 3
    localparam cache_pkg::word_t ADDR_A = 32'h0000_008c;
    localparam cache_pkg::word_t ADDR_B = 32'h0000_010c;
    localparam cache_pkg::word_t ADDR_C = 32'h0000_018c;

    logic             clk;
    logic             arst_n;
    logic             req_load;
    logic             req_store;
    cache_pkg::word_t req_addr;
    cache_pkg::word_t req_wdata;
    logic             busy;
    logic             done;
    logic             hit;
    cache_pkg::word_t rdata;

    // Reference memory and cache-state model
    cache_pkg::word_t ref_mem     [mem_pkg::RAM_WORDS];
    logic             model_valid [N_SETS][cache_pkg::WAYS];
    cache_pkg::tag_t  model_tag   [N_SETS][cache_pkg::WAYS];
    logic             model_lru   [N_SETS];     // Way used last

    int accept_count = 0;   // Requests taken by the DUT
    int done_count   = 0;   // Done pulses seen

    mem_subsystem DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_load  (req_load),
        .req_store (req_store),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .busy      (busy),
        .done      (done),
        .hit       (hit),
        .rdata     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic fail_plain(input string what);
        $display("Error at time %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s: got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s: got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Predicts the hit flag and applies the access to the model
    function automatic logic model_access(input cache_pkg::word_t addr);
        cache_pkg::set_t s;
        cache_pkg::tag_t t;
        logic            way;
        logic            is_hit;
        s      = addr[cache_pkg::OFFSET_WIDTH +: cache_pkg::SET_WIDTH];
        t      = addr[cache_pkg::DATA_WIDTH-1 -: cache_pkg::TAG_WIDTH];
        is_hit = 1'b1;
        if (model_valid[s][0] && model_tag[s][0] == t) begin
            way = 1'b0;                     // Way 0 wins a compare first
        end else if (model_valid[s][1] && model_tag[s][1] == t) begin
            way = 1'b1;
        end else begin
            is_hit = 1'b0;
            way    = !model_lru[s];         // Victim is the way not used last
            model_valid[s][way] = 1'b1;
            model_tag[s][way]   = t;
        end
        model_lru[s] = way;
        return is_hit;
    endfunction

    // One request from strobe to done, with all per-request checks
    task automatic run_request(input logic is_load, input cache_pkg::word_t addr,
                               input cache_pkg::word_t wdata,
                               output cache_pkg::word_t data);
        logic               exp_hit;
        cache_pkg::word_t   exp_data;
        mem_pkg::ram_addr_t idx;
        int                 cycles;
        int                 exp_cycles;
        idx        = addr[cache_pkg::OFFSET_WIDTH +: mem_pkg::RAM_ADDR_WIDTH];
        exp_hit    = model_access(addr);
        exp_data   = ref_mem[idx];
        exp_cycles = (is_load && !exp_hit) ? 4 : 2;     // Miss adds READ and FILL
        @(posedge clk);
        req_load  <= is_load;
        req_store <= !is_load;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge clk);                     // Accepting edge
        req_load  <= 1'b0;
        req_store <= 1'b0;
        accept_count++;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!done) begin
                check_flag("busy", busy, 1'b1);   // Held until done
            end
        end while (!done);
        check_flag("busy", busy, 1'b0);
        check_flag("hit", hit, exp_hit);
        if (is_load) begin
            check_word("rdata", rdata, exp_data);
        end else begin
            ref_mem[idx] = wdata;
        end
        if (cycles != exp_cycles) begin
            fail_plain($sformatf("request to %h took %0d cycles instead of %0d",
                                 addr, cycles, exp_cycles));
        end
        data = rdata;
    endtask

    // Done pulse framing, no pulse without an accepted request
    always @(negedge clk) begin
        if (arst_n && done) begin
            done_count++;
            if (done_count > accept_count) begin
                fail_plain("done pulse seen without an accepted request");
            end
        end
    end

    initial begin : stimulus
        logic             is_load;
        cache_pkg::word_t addr;
        cache_pkg::word_t wdata;
        cache_pkg::word_t data;
        int               hot_set;
        void'($urandom(15));
        arst_n    = 1'b0;
        req_load  = 1'b0;
        req_store = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int s = 0; s < N_SETS; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("hit", hit, 1'b0);

        // First load after reset misses and returns zero
        run_request(1'b1, 32'h0000_0040, '0, data);
        check_flag("hit", hit, 1'b0);
        check_word("rdata", data, '0);

        // Dirty line pushed out by two conflicting loads, then read back
        run_request(1'b0, ADDR_A, 32'hcafe_0001, data);
        run_request(1'b1, ADDR_B, '0, data);
        run_request(1'b1, ADDR_C, '0, data);    // Evicts the dirty line of A
        run_request(1'b1, ADDR_A, '0, data);
        check_word("rdata", data, 32'hcafe_0001);

        // Random mix, half of it aimed at four hot sets
        for (int i = 0; i < N_RANDOM; i++) begin
            is_load = ($urandom % 2) == 0;
            if (($urandom % 2) == 0) begin
                hot_set = 3 + 9 * ($urandom % 4);                  // Sets 3, 12, 21, 30
                addr = (cache_pkg::word_t'($urandom % 8) << TAG_SHIFT) |
                       (cache_pkg::word_t'(hot_set) << cache_pkg::OFFSET_WIDTH);
            end else begin
                addr = cache_pkg::word_t'($urandom % 256) << cache_pkg::OFFSET_WIDTH;
            end
            wdata = $urandom;
            run_request(is_load, addr, wdata, data);
            repeat ($urandom % 2) @(posedge clk);   // Idle gap now and then
        end

        repeat (4) @(negedge clk);
        if (done_count != accept_count) begin
            fail_plain($sformatf("%0d requests accepted but %0d done pulses seen",
                                 accept_count, done_count));
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        fail_plain("timeout, done never came for a pending request");
    end

endmodule

//--- list.f
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/l1_cache_2way.sv
rtl/cache_ctrl.sv
rtl/backing_ram.sv
rtl/mem_subsystem.sv
dv/mem_subsystem_tb.sv

//--- rtl/backing_ram.sv
//----------------------------------------------------------------------------
// Backing RAM
// Single-port word memory, write at the edge, read data one cycle later
//----------------------------------------------------------------------------
module backing_ram (
    input  logic               clk,
    input  logic               we,
    input  logic               re,
    input  mem_pkg::ram_addr_t addr,
    input  cache_pkg::word_t   wdata,
    output cache_pkg::word_t   rdata
);

    cache_pkg::word_t mem [mem_pkg::RAM_WORDS];

    // Cleared contents in place of a preload image
    initial begin
        for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        if (re) begin
            rdata <= mem[addr];     // Registered read
        end
    end

endmodule

//--- rtl/cache_ctrl.sv
//----------------------------------------------------------------------------
// Cache controller
// Sequences one load or store at a time through lookup, write-back of a
// dirty victim, refill from RAM and completion with a done pulse
//----------------------------------------------------------------------------
module cache_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    // Client side
    input  logic               req_load,
    input  logic               req_store,
    input  cache_pkg::word_t   req_addr,
    input  cache_pkg::word_t   req_wdata,
    output logic               busy,
    output logic               done,
    output logic               done_hit,
    output cache_pkg::word_t   rdata,
    // Cache side
    output cache_pkg::word_t   lookup_addr,
    output cache_pkg::word_t   store_data,
    output cache_pkg::word_t   ram_fill,
    output logic               cache_load,
    output logic               cache_store,
    input  logic               hit,
    input  logic               evict,
    input  cache_pkg::word_t   victim_addr,
    input  cache_pkg::word_t   cache_dout,
    // RAM side
    output logic               ram_we,
    output logic               ram_re,
    output mem_pkg::ram_addr_t ram_addr,
    output cache_pkg::word_t   ram_wdata,
    input  cache_pkg::word_t   ram_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,     // Hit check, store commit, write-back
        READ,       // RAM read for a load miss
        FILL        // Refill line with RAM data
    } state_t;

    state_t           state_q;
    logic             op_load_q;    // Held request is a load
    cache_pkg::word_t addr_q;
    cache_pkg::word_t wdata_q;
    logic             load_hit;

    assign load_hit = (state_q == LOOKUP) && op_load_q && hit;

    // FSM and the done framing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            op_load_q <= 1'b0;
            done      <= 1'b0;
            done_hit  <= 1'b0;
        end else begin
            done <= 1'b0;   // Single-cycle pulse
            case (state_q)
                IDLE: begin
                    if (req_load || req_store) begin
                        op_load_q <= req_load;
                        state_q   <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    done_hit <= hit;
                    if (op_load_q && !hit) begin
                        state_q <= READ;    // Write-back (if any) happens now
                    end else begin
                        state_q <= IDLE;
                        done    <= 1'b1;
                    end
                end
                READ: state_q <= FILL;
                FILL: begin
                    state_q <= IDLE;
                    done    <= 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request and load data registers
    always_ff @(posedge clk) begin
        if (state_q == IDLE && (req_load || req_store)) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        if (load_hit) begin
            rdata <= cache_dout;
        end else if (state_q == FILL) begin
            rdata <= ram_rdata;     // Same word that goes into the line
        end
    end

    assign busy = (state_q != IDLE);   // Falls with the edge that raises done

    // Cache strobes and data
    assign lookup_addr = addr_q;
    assign store_data  = wdata_q;
    assign ram_fill    = ram_rdata;
    assign cache_store = (state_q == LOOKUP) && !op_load_q;
    assign cache_load  = load_hit || (state_q == FILL);  // Hit only updates LRU

    // RAM port, write-back only from LOOKUP
    assign ram_we    = (state_q == LOOKUP) && evict;
    assign ram_re    = (state_q == READ);
    assign ram_wdata = cache_dout;      // Victim data on a miss
    assign ram_addr  = (state_q == LOOKUP) ?
                       victim_addr[cache_pkg::OFFSET_WIDTH +: mem_pkg::RAM_ADDR_WIDTH] :
                       addr_q[cache_pkg::OFFSET_WIDTH +: mem_pkg::RAM_ADDR_WIDTH];

endmodule

//--- rtl/cache_pkg.sv
//----------------------------------------------------------------------------
// Cache geometry
// Word width, address field split and the matching field types for the
// 2-way set-associative L1 cache
//----------------------------------------------------------------------------
package cache_pkg;

    localparam int DATA_WIDTH   = 32;
    localparam int OFFSET_WIDTH = 2;   // Byte offset within a word
    localparam int SET_WIDTH    = 5;   // 32 sets
    localparam int TAG_WIDTH    = DATA_WIDTH - SET_WIDTH - OFFSET_WIDTH;
    localparam int WAYS         = 2;

    // Data word, also used for full byte addresses
    typedef logic [DATA_WIDTH-1:0] word_t;

    typedef logic [SET_WIDTH-1:0] set_t;   // Set index field
    typedef logic [TAG_WIDTH-1:0] tag_t;   // Tag field, upper address bits

endpackage

//--- rtl/l1_cache_2way.sv
//----------------------------------------------------------------------------
// L1 cache array, 2-way set-associative, one word per block
// Combinational lookup with hit, dirty-evict and victim outputs; the
// arrays are written on load (miss fill) or store strobes
//----------------------------------------------------------------------------
module l1_cache_2way (
    input  logic             clk,
    input  logic             arst_n,
    input  cache_pkg::word_t lookup_addr,
    input  logic             cache_load,    // Fill on miss, LRU touch on hit
    input  logic             cache_store,   // Write store_data, mark dirty
    input  cache_pkg::word_t store_data,
    input  cache_pkg::word_t ram_fill,
    output logic             hit,
    output logic             evict,         // Victim is valid and dirty
    output cache_pkg::word_t victim_addr,
    output cache_pkg::word_t dout
);

    // State that must be known after reset
    logic valid_q [2**cache_pkg::SET_WIDTH][cache_pkg::WAYS];
    logic lru_q   [2**cache_pkg::SET_WIDTH];    // Way used last in each set

    // Plain storage arrays
    logic             dirty_mem [2**cache_pkg::SET_WIDTH][cache_pkg::WAYS];
    cache_pkg::tag_t  tag_mem   [2**cache_pkg::SET_WIDTH][cache_pkg::WAYS];
    cache_pkg::word_t data_mem  [2**cache_pkg::SET_WIDTH][cache_pkg::WAYS];

    // Lookup signals
    cache_pkg::set_t  set_idx;
    cache_pkg::tag_t  tag_in;
    logic             tag_match;
    logic             way;          // Matching way, else LRU victim
    logic             way_valid;
    logic             way_dirty;
    cache_pkg::word_t din;
    logic             write_en;

    always_comb begin
        // Address fields
        set_idx = lookup_addr[cache_pkg::OFFSET_WIDTH +: cache_pkg::SET_WIDTH];
        tag_in  = lookup_addr[cache_pkg::DATA_WIDTH-1 -: cache_pkg::TAG_WIDTH];

        // Way 0 is compared first
        if (tag_mem[set_idx][0] == tag_in) begin
            tag_match = 1'b1;
            way       = 1'b0;
        end else if (tag_mem[set_idx][1] == tag_in) begin
            tag_match = 1'b1;
            way       = 1'b1;
        end else begin
            tag_match = 1'b0;
            way       = !lru_q[set_idx];    // Not the way used last
        end

        way_valid = valid_q[set_idx][way];
        way_dirty = dirty_mem[set_idx][way];

        // A tag match on an invalid line still misses
        hit   = tag_match && way_valid;
        evict = !tag_match && way_valid && way_dirty;   // Controller decides use

        // Rebuild the victim byte address from its tag and this set
        victim_addr = {tag_mem[set_idx][way], set_idx, {cache_pkg::OFFSET_WIDTH{1'b0}}};
        dout        = data_mem[set_idx][way];

        din      = cache_store ? store_data : ram_fill;
        write_en = cache_store || (cache_load && !hit);  // Load hit writes nothing
    end

    // Valid and LRU bits, cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < 2**cache_pkg::SET_WIDTH; s++) begin
                lru_q[s] <= 1'b0;
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                end
            end
        end else begin
            if (write_en) begin
                valid_q[set_idx][way] <= 1'b1;
            end
            if (cache_load || cache_store) begin
                lru_q[set_idx] <= way;      // Record way just used
            end
        end
    end

    // Tag, dirty and data storage
    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[set_idx][way]   <= tag_in;
            dirty_mem[set_idx][way] <= cache_store;   // Fills come in clean
            data_mem[set_idx][way]  <= din;
        end
    end

endmodule

//--- rtl/mem_pkg.sv
//----------------------------------------------------------------------------
// Backing RAM geometry
// Depth and word address type of the RAM behind the cache
//----------------------------------------------------------------------------
package mem_pkg;

    localparam int RAM_ADDR_WIDTH = 8;
    localparam int RAM_WORDS      = 2**RAM_ADDR_WIDTH;   // 256 words

    // Word address, byte address bits 9:2; higher bits alias
    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

endpackage

//--- rtl/mem_subsystem.sv
//----------------------------------------------------------------------------
// Memory subsystem top
// Cache controller, 2-way L1 cache array and backing RAM
//----------------------------------------------------------------------------
module mem_subsystem (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             req_load,
    input  logic             req_store,
    input  cache_pkg::word_t req_addr,
    input  cache_pkg::word_t req_wdata,
    output logic             busy,
    output logic             done,
    output logic             hit,      // Valid in the done cycle
    output cache_pkg::word_t rdata
);

    // Controller to cache
    cache_pkg::word_t   lookup_addr;
    cache_pkg::word_t   store_data;
    cache_pkg::word_t   ram_fill;
    logic               cache_load;
    logic               cache_store;
    logic               cache_hit;
    logic               evict;
    cache_pkg::word_t   victim_addr;
    cache_pkg::word_t   cache_dout;

    // Controller to RAM
    logic               ram_we;
    logic               ram_re;
    mem_pkg::ram_addr_t ram_addr;
    cache_pkg::word_t   ram_wdata;
    cache_pkg::word_t   ram_rdata;

    cache_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_load    (req_load),
        .req_store   (req_store),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .busy        (busy),
        .done        (done),
        .done_hit    (hit),
        .rdata       (rdata),
        .lookup_addr (lookup_addr),
        .store_data  (store_data),
        .ram_fill    (ram_fill),
        .cache_load  (cache_load),
        .cache_store (cache_store),
        .hit         (cache_hit),
        .evict       (evict),
        .victim_addr (victim_addr),
        .cache_dout  (cache_dout),
        .ram_we      (ram_we),
        .ram_re      (ram_re),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata)
    );

    l1_cache_2way u_cache (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup_addr (lookup_addr),
        .cache_load  (cache_load),
        .cache_store (cache_store),
        .store_data  (store_data),
        .ram_fill    (ram_fill),
        .hit         (cache_hit),
        .evict       (evict),
        .victim_addr (victim_addr),
        .dout        (cache_dout)
    );

    backing_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .re    (ram_re),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule
